//--- exe_defines.svh
`ifndef EXE_DEFINES_SVH
`define EXE_DEFINES_SVH

// data path width
`define EXE_XLEN 32

// opcode field width, holds every alu_op_e value
`define EXE_OP_W 5

// multiplier register stages
`define EXE_MUL_STAGES 3

// restoring divider, one quotient bit per step
`define EXE_DIV_STEPS `EXE_XLEN

`endif

//--- exe_pkg.sv
`include "exe_defines.svh"

package exe_pkg;

    typedef enum logic [`EXE_OP_W-1:0] {
        OP_ADD   = 5'd0,
        OP_ADDU  = 5'd1,
        OP_SUB   = 5'd2,
        OP_SUBU  = 5'd3,
        OP_SLT   = 5'd4,
        OP_SLTU  = 5'd5,
        OP_AND   = 5'd6,
        OP_OR    = 5'd7,
        OP_XOR   = 5'd8,
        OP_NOR   = 5'd9,
        OP_SLL   = 5'd10,
        OP_SRL   = 5'd11,
        OP_SRA   = 5'd12,
        OP_LUI   = 5'd13,
        OP_CLO   = 5'd14,
        OP_CLZ   = 5'd15,
        OP_MULT  = 5'd16,  // multiply/divide unit from here on
        OP_MULTU = 5'd17,
        OP_MADD  = 5'd18,
        OP_DIV   = 5'd19,
        OP_DIVU  = 5'd20,
        OP_MFHI  = 5'd21,
        OP_MFLO  = 5'd22,
        OP_MTHI  = 5'd23,
        OP_MTLO  = 5'd24
    } alu_op_e;

    typedef enum logic {
        UNIT_INT = 1'b0,
        UNIT_MD  = 1'b1
    } unit_e;

    typedef enum logic [1:0] {MD_IDLE, MD_MUL, MD_DIV, MD_DONE} md_state_e;

endpackage

//--- exe_if.sv
`timescale 1ns/1ps
`include "exe_defines.svh"

interface exe_if;

    logic                 valid;  // one-cycle launch pulse
    exe_pkg::alu_op_e     op;
    exe_pkg::unit_e       unit;
    logic [`EXE_XLEN-1:0] src1;
    logic [`EXE_XLEN-1:0] src2;

    modport src (
        output valid,
        output op,
        output unit,
        output src1,
        output src2
    );

    modport dst (
        input valid,
        input op,
        input unit,
        input src1,
        input src2
    );

endinterface

//--- exe_issue.sv
`timescale 1ns/1ps
`include "exe_defines.svh"

module exe_issue (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 req,
    input  logic [`EXE_OP_W-1:0] op,
    input  logic [`EXE_XLEN-1:0] src1,
    input  logic [`EXE_XLEN-1:0] src2,
    input  logic                 ack,
    exe_if.src                   issue_link
);

    logic             armed;
    logic             launch;
    exe_pkg::alu_op_e op_dec;

    function automatic exe_pkg::unit_e classify(input exe_pkg::alu_op_e o);
        case (o)
            exe_pkg::OP_MULT, exe_pkg::OP_MULTU, exe_pkg::OP_MADD,
            exe_pkg::OP_DIV, exe_pkg::OP_DIVU,
            exe_pkg::OP_MFHI, exe_pkg::OP_MFLO,
            exe_pkg::OP_MTHI, exe_pkg::OP_MTLO: return exe_pkg::UNIT_MD;
            default:                            return exe_pkg::UNIT_INT;
        endcase
    endfunction

    assign op_dec = exe_pkg::alu_op_e'(op);
    assign launch = armed && req && !ack;  // new request, previous one closed

    always_ff @(posedge clk) begin
        if (reset) begin
            armed            <= 1'b1;
            issue_link.valid <= 1'b0;
        end else begin
            issue_link.valid <= launch;
            if (launch) begin
                armed <= 1'b0;
            end else if (!req) begin
                armed <= 1'b1;  // host closed the handshake
            end
        end
    end

    // operands held until the next launch
    always_ff @(posedge clk) begin
        if (launch) begin
            issue_link.op   <= op_dec;
            issue_link.unit <= classify(op_dec);
            issue_link.src1 <= src1;
            issue_link.src2 <= src2;
        end
    end

endmodule

//--- exe_int_alu.sv
`timescale 1ns/1ps
`include "exe_defines.svh"

module exe_int_alu (
    exe_if.dst                   issue_link,
    output logic [`EXE_XLEN-1:0] int_result,
    output logic                 int_ovf
);

    localparam int XLEN = `EXE_XLEN;
    localparam int SH_W = $clog2(XLEN);

    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic [XLEN-1:0] lead_cnt;
    logic [SH_W-1:0] shamt;

    function automatic logic [XLEN-1:0] count_leading_zeros(input logic [XLEN-1:0] v);
        logic [XLEN-1:0] n;
        logic            found;
        n     = '0;
        found = 1'b0;
        for (int i = XLEN - 1; i >= 0; i--) begin
            if (v[i]) begin
                found = 1'b1;
            end else if (!found) begin
                n = n + 1'b1;
            end
        end
        return n;
    endfunction

    assign a     = issue_link.src1;
    assign b     = issue_link.src2;
    assign sum   = a + b;
    assign diff  = a - b;
    assign shamt = a[SH_W-1:0];  // shift amount from src1, src2 is shifted

    // leading ones are leading zeros of the inverted word
    assign lead_cnt = count_leading_zeros((issue_link.op == exe_pkg::OP_CLO) ? ~a : a);

    always_comb begin
        int_result = '0;
        int_ovf    = 1'b0;
        case (issue_link.op)
            exe_pkg::OP_ADD: begin
                int_result = sum;
                int_ovf    = (a[XLEN-1] == b[XLEN-1]) && (sum[XLEN-1] != a[XLEN-1]);
            end
            exe_pkg::OP_SUB: begin
                int_result = diff;
                int_ovf    = (a[XLEN-1] != b[XLEN-1]) && (diff[XLEN-1] != a[XLEN-1]);
            end
            exe_pkg::OP_ADDU: int_result = sum;
            exe_pkg::OP_SUBU: int_result = diff;
            exe_pkg::OP_SLT:  int_result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            exe_pkg::OP_SLTU: int_result = {{(XLEN-1){1'b0}}, a < b};
            exe_pkg::OP_AND:  int_result = a & b;
            exe_pkg::OP_OR:   int_result = a | b;
            exe_pkg::OP_XOR:  int_result = a ^ b;
            exe_pkg::OP_NOR:  int_result = ~(a | b);
            exe_pkg::OP_SLL:  int_result = b << shamt;
            exe_pkg::OP_SRL:  int_result = b >> shamt;
            exe_pkg::OP_SRA:  int_result = $signed(b) >>> shamt;
            exe_pkg::OP_LUI:  int_result = {b[XLEN/2-1:0], {(XLEN/2){1'b0}}};
            exe_pkg::OP_CLO,
            exe_pkg::OP_CLZ:  int_result = lead_cnt;
            default:          int_result = '0;  // multiply/divide ops
        endcase
    end

endmodule

//--- exe_muldiv.sv
`timescale 1ns/1ps
`include "exe_defines.svh"

module exe_muldiv (
    input  logic                 clk,
    input  logic                 reset,
    exe_if.dst                   issue_link,
    output logic [`EXE_XLEN-1:0] md_result,
    output logic                 md_done
);

    localparam int XLEN  = `EXE_XLEN;
    localparam int CNT_W = $clog2(`EXE_DIV_STEPS) + 1;

    exe_pkg::md_state_e  state;
    logic [CNT_W-1:0]    cnt;
    logic [XLEN-1:0]     hi;
    logic [XLEN-1:0]     lo;
    logic                start;
    logic                is_mul;
    logic                is_div;
    logic                is_signed;
    logic [XLEN-1:0]     mag_a;
    logic [XLEN-1:0]     mag_b;
    logic [XLEN-1:0]     mul_a_q;
    logic [XLEN-1:0]     mul_b_q;
    logic                mul_neg1_q;
    logic                mul_neg2_q;
    logic [2*XLEN-1:0]   mul_mag_q;
    logic [2*XLEN-1:0]   prod_q;
    logic [XLEN-1:0]     rem_q;
    logic [XLEN-1:0]     quo_q;
    logic [XLEN-1:0]     rem_in;
    logic [XLEN-1:0]     quo_in;
    logic [XLEN:0]       trial;
    logic [XLEN-1:0]     rem_fix;
    logic [XLEN-1:0]     quo_fix;

    function automatic logic [XLEN-1:0] magnitude(input logic [XLEN-1:0] v, input logic sgn);
        return (sgn && v[XLEN-1]) ? -v : v;
    endfunction

    assign start     = issue_link.valid && (issue_link.unit == exe_pkg::UNIT_MD);
    assign is_mul    = issue_link.op inside {exe_pkg::OP_MULT, exe_pkg::OP_MULTU,
                                             exe_pkg::OP_MADD};
    assign is_div    = issue_link.op inside {exe_pkg::OP_DIV, exe_pkg::OP_DIVU};
    assign is_signed = issue_link.op inside {exe_pkg::OP_MULT, exe_pkg::OP_MADD,
                                             exe_pkg::OP_DIV};
    assign mag_a     = magnitude(issue_link.src1, is_signed);
    assign mag_b     = magnitude(issue_link.src2, is_signed);

    // three register stages: operands, magnitude product, sign fix
    always_ff @(posedge clk) begin
        mul_a_q    <= mag_a;
        mul_b_q    <= mag_b;
        mul_neg1_q <= is_signed && (issue_link.src1[XLEN-1] ^ issue_link.src2[XLEN-1]);
        mul_mag_q  <= (2*XLEN)'(mul_a_q) * (2*XLEN)'(mul_b_q);
        mul_neg2_q <= mul_neg1_q;
        prod_q     <= mul_neg2_q ? -mul_mag_q : mul_mag_q;
    end

    // first step runs straight off the issue registers
    assign rem_in = (state == exe_pkg::MD_DIV) ? rem_q : '0;
    assign quo_in = (state == exe_pkg::MD_DIV) ? quo_q : mag_a;
    assign trial  = {rem_in, quo_in[XLEN-1]} - {1'b0, mag_b};

    always_ff @(posedge clk) begin
        if (state == exe_pkg::MD_DIV || start) begin
            rem_q <= trial[XLEN] ? {rem_in[XLEN-2:0], quo_in[XLEN-1]} : trial[XLEN-1:0];
            quo_q <= {quo_in[XLEN-2:0], ~trial[XLEN]};
        end
    end

    assign rem_fix = (is_signed && issue_link.src1[XLEN-1]) ? -rem_q : rem_q;
    assign quo_fix = (issue_link.src2 == '0) ? '1 :
                     (is_signed && (issue_link.src1[XLEN-1] ^ issue_link.src2[XLEN-1])) ?
                     -quo_q : quo_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= exe_pkg::MD_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                exe_pkg::MD_IDLE: begin
                    cnt <= CNT_W'(1);
                    if (start && is_mul) begin
                        state <= exe_pkg::MD_MUL;
                    end else if (start && is_div) begin
                        state <= exe_pkg::MD_DIV;
                    end
                end
                exe_pkg::MD_MUL: begin
                    cnt <= cnt + CNT_W'(1);
                    if (cnt == CNT_W'(`EXE_MUL_STAGES - 1)) begin
                        state <= exe_pkg::MD_DONE;
                    end
                end
                exe_pkg::MD_DIV: begin
                    cnt <= cnt + CNT_W'(1);
                    if (cnt == CNT_W'(`EXE_DIV_STEPS - 1)) begin
                        state <= exe_pkg::MD_DONE;
                    end
                end
                default: state <= exe_pkg::MD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (state == exe_pkg::MD_DONE) begin
            case (issue_link.op)
                exe_pkg::OP_MULT,
                exe_pkg::OP_MULTU: {hi, lo} <= prod_q;
                exe_pkg::OP_MADD:  {hi, lo} <= {hi, lo} + prod_q;
                default: begin
                    hi <= rem_fix;  // remainder to hi, quotient to lo
                    lo <= quo_fix;
                end
            endcase
        end else if (start && issue_link.op == exe_pkg::OP_MTHI) begin
            hi <= issue_link.src1;
        end else if (start && issue_link.op == exe_pkg::OP_MTLO) begin
            lo <= issue_link.src1;
        end
    end

    // hi/lo moves finish in the launch cycle
    assign md_done   = (state == exe_pkg::MD_DONE) || (start && !is_mul && !is_div);
    assign md_result = (issue_link.op == exe_pkg::OP_MFHI) ? hi :
                       (issue_link.op == exe_pkg::OP_MFLO) ? lo : '0;

endmodule

//--- exe_result.sv
`timescale 1ns/1ps
`include "exe_defines.svh"

module exe_result (
    input  logic                 clk,
    input  logic                 reset,
    exe_if.dst                   issue_link,
    input  logic [`EXE_XLEN-1:0] int_result,
    input  logic                 int_ovf,
    input  logic [`EXE_XLEN-1:0] md_result,
    input  logic                 md_done,
    input  logic                 req,
    output logic                 ack,
    output logic [`EXE_XLEN-1:0] result,
    output logic                 ovf
);

    logic pending;
    logic int_fin;

    assign int_fin = issue_link.valid && (issue_link.unit == exe_pkg::UNIT_INT);

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
            ack     <= 1'b0;
            ovf     <= 1'b0;
        end else begin
            pending <= int_fin || md_done;
            if (int_fin) begin
                ovf <= int_ovf;
            end else if (md_done) begin
                ovf <= 1'b0;  // no overflow from multiply/divide
            end
            if (pending) begin
                ack <= 1'b1;
            end else if (!req) begin
                ack <= 1'b0;  // host closed, drop ack
            end
        end
    end

    always_ff @(posedge clk) begin
        if (int_fin) begin
            result <= int_result;
        end else if (md_done) begin
            result <= md_result;
        end
    end

endmodule

//--- exe_top.sv
`timescale 1ns/1ps
`include "exe_defines.svh"

module exe_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 req,
    input  logic [`EXE_OP_W-1:0] op,
    input  logic [`EXE_XLEN-1:0] src1,
    input  logic [`EXE_XLEN-1:0] src2,
    output logic                 ack,
    output logic [`EXE_XLEN-1:0] result,
    output logic                 ovf
);

    exe_if issue_link ();

    logic [`EXE_XLEN-1:0] int_result;
    logic                 int_ovf;
    logic [`EXE_XLEN-1:0] md_result;
    logic                 md_done;

    exe_issue i_issue (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .op         (op),
        .src1       (src1),
        .src2       (src2),
        .ack        (ack),  // closes the loop for rearm
        .issue_link (issue_link.src)
    );

    exe_int_alu i_int_alu (
        .issue_link (issue_link.dst),
        .int_result (int_result),
        .int_ovf    (int_ovf)
    );

    exe_muldiv i_muldiv (
        .clk        (clk),
        .reset      (reset),
        .issue_link (issue_link.dst),
        .md_result  (md_result),
        .md_done    (md_done)
    );

    exe_result i_result (
        .clk        (clk),
        .reset      (reset),
        .issue_link (issue_link.dst),
        .int_result (int_result),
        .int_ovf    (int_ovf),
        .md_result  (md_result),
        .md_done    (md_done),
        .req        (req),
        .ack        (ack),
        .result     (result),
        .ovf        (ovf)
    );

endmodule

//--- tb_exe.sv
`timescale 1ns/1ps
`include "exe_defines.svh"

module tb_exe;

    localparam int CLK_PERIOD = 10;
    localparam int N_RAND     = 40;

    typedef struct packed {
        exe_pkg::alu_op_e     op;
        logic [`EXE_XLEN-1:0] a;
        logic [`EXE_XLEN-1:0] b;
        logic [`EXE_XLEN-1:0] res;
        logic                 ovf;
    } vec_t;

    logic                 clk;
    logic                 reset;
    logic                 req;
    logic [`EXE_OP_W-1:0] op;
    logic [`EXE_XLEN-1:0] src1;
    logic [`EXE_XLEN-1:0] src2;
    logic                 ack;
    logic [`EXE_XLEN-1:0] result;
    logic                 ovf;

    vec_t        table_q[$];
    logic [31:0] lcg_state;

    exe_top i_dut (
        .clk    (clk),
        .reset  (reset),
        .req    (req),
        .op     (op),
        .src1   (src1),
        .src2   (src2),
        .ack    (ack),
        .result (result),
        .ovf    (ovf)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            $display("Checks failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // reference for the integer unit
    function automatic void ref_int(input exe_pkg::alu_op_e o, input logic [31:0] a,
                                    input logic [31:0] b, output logic [31:0] res,
                                    output logic ov);
        longint sum_s;
        longint dif_s;
        int     n;
        logic   want;
        sum_s = longint'($signed(a)) + longint'($signed(b));
        dif_s = longint'($signed(a)) - longint'($signed(b));
        want  = (o == exe_pkg::OP_CLO);
        n     = 0;
        ov    = 1'b0;
        for (int i = 31; i >= 0 && a[i] == want; i--) begin
            n++;
        end
        case (o)
            exe_pkg::OP_ADD: begin
                res = sum_s[31:0];
                ov  = sum_s != longint'($signed(sum_s[31:0]));  // does not fit 32 bits
            end
            exe_pkg::OP_SUB: begin
                res = dif_s[31:0];
                ov  = dif_s != longint'($signed(dif_s[31:0]));
            end
            exe_pkg::OP_ADDU: res = sum_s[31:0];
            exe_pkg::OP_SUBU: res = dif_s[31:0];
            exe_pkg::OP_SLT:  res = {31'b0, $signed(a) < $signed(b)};
            exe_pkg::OP_SLTU: res = {31'b0, a < b};
            exe_pkg::OP_AND:  res = a & b;
            exe_pkg::OP_OR:   res = a | b;
            exe_pkg::OP_XOR:  res = a ^ b;
            exe_pkg::OP_NOR:  res = ~(a | b);
            exe_pkg::OP_SLL:  res = b << a[4:0];
            exe_pkg::OP_SRL:  res = b >> a[4:0];
            exe_pkg::OP_SRA:  res = $signed(b) >>> a[4:0];
            exe_pkg::OP_LUI:  res = {b[15:0], 16'h0000};
            exe_pkg::OP_CLO,
            exe_pkg::OP_CLZ:  res = n;
            default:          res = '0;
        endcase
    endfunction

    function automatic int expected_latency(input exe_pkg::alu_op_e o);
        case (o)
            exe_pkg::OP_MULT, exe_pkg::OP_MULTU, exe_pkg::OP_MADD: return `EXE_MUL_STAGES + 2;
            exe_pkg::OP_DIV, exe_pkg::OP_DIVU:                     return `EXE_DIV_STEPS + 2;
            default:                                               return 2;
        endcase
    endfunction

    task automatic add_vec(input exe_pkg::alu_op_e o, input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] res, input logic ov);
        table_q.push_back(vec_t'{o, a, b, res, ov});
    endtask

    task automatic fill_table();
        add_vec(exe_pkg::OP_ADD,   32'h7fffffff, 32'h00000001, 32'h80000000, 1'b1);
        add_vec(exe_pkg::OP_ADDU,  32'h7fffffff, 32'h00000001, 32'h80000000, 1'b0);
        add_vec(exe_pkg::OP_SUB,   32'h80000000, 32'h00000001, 32'h7fffffff, 1'b1);
        add_vec(exe_pkg::OP_SUBU,  32'h80000000, 32'h00000001, 32'h7fffffff, 1'b0);
        add_vec(exe_pkg::OP_ADD,   32'hffffffff, 32'h00000001, 32'h00000000, 1'b0);
        add_vec(exe_pkg::OP_SLT,   32'h80000000, 32'h00000000, 32'h00000001, 1'b0);
        add_vec(exe_pkg::OP_SLTU,  32'h80000000, 32'h00000000, 32'h00000000, 1'b0);
        add_vec(exe_pkg::OP_SLTU,  32'h00000000, 32'hffffffff, 32'h00000001, 1'b0);
        add_vec(exe_pkg::OP_AND,   32'hffffffff, 32'h80000000, 32'h80000000, 1'b0);
        add_vec(exe_pkg::OP_OR,    32'h00000000, 32'h80000000, 32'h80000000, 1'b0);
        add_vec(exe_pkg::OP_XOR,   32'hffffffff, 32'h80000000, 32'h7fffffff, 1'b0);
        add_vec(exe_pkg::OP_NOR,   32'h00000000, 32'h00000000, 32'hffffffff, 1'b0);
        add_vec(exe_pkg::OP_SLL,   32'h0000001f, 32'h00000001, 32'h80000000, 1'b0);
        add_vec(exe_pkg::OP_SRL,   32'h00000024, 32'hffffffff, 32'h0fffffff, 1'b0);  // amount 4
        add_vec(exe_pkg::OP_SRA,   32'h0000001f, 32'h80000000, 32'hffffffff, 1'b0);
        add_vec(exe_pkg::OP_LUI,   32'h00000000, 32'hffff1234, 32'h12340000, 1'b0);
        add_vec(exe_pkg::OP_CLO,   32'hffffffff, 32'h00000000, 32'h00000020, 1'b0);
        add_vec(exe_pkg::OP_CLO,   32'h80000000, 32'h00000000, 32'h00000001, 1'b0);
        add_vec(exe_pkg::OP_CLO,   32'h00000000, 32'h00000000, 32'h00000000, 1'b0);
        add_vec(exe_pkg::OP_CLZ,   32'h00000000, 32'h00000000, 32'h00000020, 1'b0);
        add_vec(exe_pkg::OP_CLZ,   32'h00000001, 32'h00000000, 32'h0000001f, 1'b0);
        add_vec(exe_pkg::OP_CLZ,   32'h80000000, 32'h00000000, 32'h00000000, 1'b0);
        add_vec(exe_pkg::OP_CLZ,   32'hffffffff, 32'h00000000, 32'h00000000, 1'b0);
        add_vec(exe_pkg::OP_MULT,  32'hfffffffe, 32'h00000003, 32'h00000000, 1'b0);  // -2 * 3
        add_vec(exe_pkg::OP_MFHI,  32'h00000000, 32'h00000000, 32'hffffffff, 1'b0);
        add_vec(exe_pkg::OP_MFLO,  32'h00000000, 32'h00000000, 32'hfffffffa, 1'b0);
        add_vec(exe_pkg::OP_MULTU, 32'hffffffff, 32'hffffffff, 32'h00000000, 1'b0);
        add_vec(exe_pkg::OP_MFHI,  32'h00000000, 32'h00000000, 32'hfffffffe, 1'b0);
        add_vec(exe_pkg::OP_MFLO,  32'h00000000, 32'h00000000, 32'h00000001, 1'b0);
        add_vec(exe_pkg::OP_MADD,  32'h00010000, 32'hffff0000, 32'h00000000, 1'b0);  // adds -2^32
        add_vec(exe_pkg::OP_MFHI,  32'h00000000, 32'h00000000, 32'hfffffffd, 1'b0);
        add_vec(exe_pkg::OP_MFLO,  32'h00000000, 32'h00000000, 32'h00000001, 1'b0);
        add_vec(exe_pkg::OP_DIV,   32'hfffffff9, 32'h00000002, 32'h00000000, 1'b0);  // -7 / 2
        add_vec(exe_pkg::OP_MFLO,  32'h00000000, 32'h00000000, 32'hfffffffd, 1'b0);
        add_vec(exe_pkg::OP_MFHI,  32'h00000000, 32'h00000000, 32'hffffffff, 1'b0);
        add_vec(exe_pkg::OP_DIV,   32'hfffffff9, 32'hfffffffe, 32'h00000000, 1'b0);  // -7 / -2
        add_vec(exe_pkg::OP_MFLO,  32'h00000000, 32'h00000000, 32'h00000003, 1'b0);
        add_vec(exe_pkg::OP_MFHI,  32'h00000000, 32'h00000000, 32'hffffffff, 1'b0);
        add_vec(exe_pkg::OP_DIVU,  32'hffffffff, 32'h00000010, 32'h00000000, 1'b0);
        add_vec(exe_pkg::OP_MFLO,  32'h00000000, 32'h00000000, 32'h0fffffff, 1'b0);
        add_vec(exe_pkg::OP_MFHI,  32'h00000000, 32'h00000000, 32'h0000000f, 1'b0);
        add_vec(exe_pkg::OP_DIVU,  32'h12345678, 32'h00000000, 32'h00000000, 1'b0);
        add_vec(exe_pkg::OP_MFLO,  32'h00000000, 32'h00000000, 32'hffffffff, 1'b0);
        add_vec(exe_pkg::OP_MFHI,  32'h00000000, 32'h00000000, 32'h12345678, 1'b0);
        add_vec(exe_pkg::OP_DIV,   32'hfffffff9, 32'h00000000, 32'h00000000, 1'b0);
        add_vec(exe_pkg::OP_MFLO,  32'h00000000, 32'h00000000, 32'hffffffff, 1'b0);
        add_vec(exe_pkg::OP_MFHI,  32'h00000000, 32'h00000000, 32'hfffffff9, 1'b0);
        add_vec(exe_pkg::OP_MTHI,  32'hcafef00d, 32'h00000000, 32'h00000000, 1'b0);
        add_vec(exe_pkg::OP_MTLO,  32'h0badbeef, 32'h00000000, 32'h00000000, 1'b0);
        add_vec(exe_pkg::OP_ADD,   32'h7fffffff, 32'h00000001, 32'h80000000, 1'b1);
        add_vec(exe_pkg::OP_MFHI,  32'h00000000, 32'h00000000, 32'hcafef00d, 1'b0);
        add_vec(exe_pkg::OP_MFLO,  32'h00000000, 32'h00000000, 32'h0badbeef, 1'b0);
    endtask

    // one full four-phase handshake starting 1 ns after a rising edge
    task automatic run_instr(input vec_t v);
        int          lat;
        logic [31:0] held;
        lat  = 0;
        op   = v.op;
        src1 = v.a;
        src2 = v.b;
        req  = 1'b1;
        @(posedge clk);  // edge that samples req
        #1;
        while (!ack) begin
            @(posedge clk);
            #1;
            lat++;
        end
        check_val("ack_latency", lat, expected_latency(v.op));
        check_val("result", result, v.res);
        check_val("ovf", {31'b0, ovf}, {31'b0, v.ovf});
        held = result;
        @(posedge clk);
        #1;
        check_val("ack_hold", {31'b0, ack}, 32'd1);
        check_val("result_hold", result, held);
        req = 1'b0;
        @(posedge clk);
        #1;
        check_val("ack_release", {31'b0, ack}, 32'd0);
    endtask

    initial begin
        vec_t        v;
        logic [31:0] r;
        clk       = 1'b0;
        reset     = 1'b1;
        req       = 1'b0;
        op        = '0;
        src1      = '0;
        src2      = '0;
        lcg_state = 32'd64;
        fill_table();
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        foreach (table_q[i]) begin
            run_instr(table_q[i]);
        end
        repeat (N_RAND) begin
            r    = lcg_next();
            v.op = exe_pkg::alu_op_e'({1'b0, r[19:16]});  // integer ops only
            v.a  = lcg_next();
            v.b  = lcg_next();
            ref_int(v.op, v.a, v.b, v.res, v.ovf);
            run_instr(v);
        end
        $display("All checks passed");
        $finish;
    end

    initial begin
        longint limit;
        #1;
        limit = longint'(table_q.size() + N_RAND) * (`EXE_DIV_STEPS + 10) * CLK_PERIOD
                + 100 * CLK_PERIOD;
        #(limit);
        $display("timeout, the DUT did not finish the handshakes in time");
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- project.f
+incdir+.
exe_pkg.sv
exe_if.sv
exe_issue.sv
exe_int_alu.sv
exe_muldiv.sv
exe_result.sv
exe_top.sv
tb_exe.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f project.f --top-module tb_exe -o tb_exe

./obj_dir/tb_exe > sim.log 2>&1 || true
cat sim.log

if grep -qx "All checks passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
